// ==== add_sub_unit.sv ====
// Registered adder and subtractor
module add_sub_unit (
    input  logic   clk,
    input  logic   nRST,
    arith_if.unit  bus,
    input  logic   sub
);

    // Extra top bit holds carry out or borrow
    logic [calc_pkg::data_width:0] sum;

    always_comb begin
        if (sub) begin
            sum = {1'b0, bus.a} - {1'b0, bus.b};
        end else begin
            sum = {1'b0, bus.a} + {1'b0, bus.b};
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            bus.done <= 1'b0;
        end else begin
            bus.done <= bus.start;
        end
    end

    // Result and overflow hold until the next start
    always_ff @(posedge clk) begin
        if (bus.start) begin
            bus.result <= sum[calc_pkg::data_width-1:0];
            bus.overflow <= sum[calc_pkg::data_width];
        end
    end

endmodule

// ==== arith_if.sv ====
// Arithmetic unit handshake
interface arith_if;

    logic start;
    logic [calc_pkg::data_width-1:0] a;
    logic [calc_pkg::data_width-1:0] b;
    logic [calc_pkg::data_width-1:0] result;
    logic done;
    logic overflow;

    modport master (
        output start,
        output a,
        output b,
        input  result,
        input  done,
        input  overflow
    );

    modport unit (
        input  start,
        input  a,
        input  b,
        output result,
        output done,
        output overflow
    );

endinterface

// ==== calc_pkg.sv ====
// Calculator arithmetic definitions
package calc_pkg;

    // Operand and result width
    localparam int data_width = 16;
    localparam int digit_width = 4;

    // Scale factor for decimal entry
    localparam logic [data_width-1:0] radix = 10;

    // Multiplier iteration count, one multiplier bit per cycle
    localparam int mult_cycles = 16;
    localparam int mult_count_width = $clog2(mult_cycles);

    typedef logic [mult_count_width-1:0] mult_count_t;

    localparam mult_count_t mult_last = mult_count_t'(mult_cycles - 1);

    // Operator keys, one-hot
    typedef enum logic [2:0] {
        op_none = 3'b000,
        op_add  = 3'b001,
        op_sub  = 3'b010,
        op_mul  = 3'b100
    } op_t;

    // Entry controller states
    typedef enum logic [2:0] {
        wait_key1,
        scale1,
        wait_op,
        wait_key2,
        scale2,
        execute,
        wait_result,
        show
    } entry_state_t;

endpackage

// ==== calc_regs.sv ====
// Wishbone register block
module calc_regs (
    input  logic                                   clk,
    input  logic                                   nRST,
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  logic [calc_regs_pkg::wb_adr_width-1:0] wb_adr,
    input  logic [calc_pkg::data_width-1:0]        wb_dat_w,
    output logic [calc_pkg::data_width-1:0]        wb_dat_r,
    output logic                                   wb_ack,
    output logic                                   enable,
    output logic                                   clear,
    input  logic                                   busy,
    input  logic                                   result_valid,
    input  logic [calc_pkg::data_width-1:0]        result,
    input  logic                                   overflow
);

    calc_regs_pkg::ctrl_t ctrl;
    calc_regs_pkg::ctrl_t ctrl_rd;

    logic [calc_pkg::data_width-1:0] result_q;
    logic [calc_pkg::data_width-1:0] op_count;
    logic [calc_pkg::data_width-1:0] status_word;
    logic overflow_q;
    logic wr_ctrl;

    assign enable = ctrl.enable;
    assign clear = ctrl.clear;

    // Write lands on the ack cycle
    assign wr_ctrl = wb_ack && wb_we && (wb_adr == calc_regs_pkg::reg_control);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            wb_ack <= 1'b0;
            ctrl.enable <= 1'b1;
            ctrl.clear <= 1'b0;
            result_q <= '0;
            overflow_q <= 1'b0;
            op_count <= '0;
        end else begin
            // One-cycle ack, drops even with stb held
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
            ctrl.clear <= 1'b0;
            if (wr_ctrl) begin
                ctrl.enable <= wb_dat_w[0];
                ctrl.clear <= wb_dat_w[1];
            end
            if (result_valid) begin
                result_q <= result;
                overflow_q <= overflow;
                op_count <= op_count + 1'b1;
            end
        end
    end

    always_comb begin
        ctrl_rd = ctrl;
        ctrl_rd.clear = 1'b0;
        status_word = '0;
        status_word[calc_regs_pkg::status_busy] = busy;
        status_word[calc_regs_pkg::status_overflow] = overflow_q;
    end

    always_comb begin
        case (wb_adr)
            calc_regs_pkg::reg_control: begin
                wb_dat_r = {{(calc_pkg::data_width - $bits(calc_regs_pkg::ctrl_t)){1'b0}},
                            ctrl_rd};
            end
            calc_regs_pkg::reg_status: wb_dat_r = status_word;
            calc_regs_pkg::reg_result: wb_dat_r = result_q;
            default:                   wb_dat_r = op_count;
        endcase
    end

endmodule

// ==== calc_regs_pkg.sv ====
// Calculator register map
package calc_regs_pkg;

    localparam int wb_adr_width = 2;

    // Word addresses
    localparam logic [wb_adr_width-1:0] reg_control = 2'd0;
    localparam logic [wb_adr_width-1:0] reg_status = 2'd1;
    localparam logic [wb_adr_width-1:0] reg_result = 2'd2;
    localparam logic [wb_adr_width-1:0] reg_op_count = 2'd3;

    // Control word, clear is self-clearing
    typedef struct packed {
        logic clear;
        logic enable;
    } ctrl_t;

    // Status bit positions
    localparam int status_busy = 0;
    localparam int status_overflow = 1;

endpackage

// ==== entry_controller.sv ====
// Keypad entry and expression control
module entry_controller (
    input  logic                              clk,
    input  logic                              nRST,
    input  logic [calc_pkg::digit_width-1:0]  digit,
    input  logic                              key_valid,
    input  calc_pkg::op_t                     op_in,
    input  logic                              equal_in,
    input  logic                              enable,
    input  logic                              clear,
    output logic                              key_ready,
    output logic                              busy,
    output logic                              complete,
    output logic [calc_pkg::data_width-1:0]   display_out,
    output logic                              overflow,
    output logic                              sub,
    arith_if.master                           add_bus,
    arith_if.master                           mul_bus
);

    calc_pkg::entry_state_t state, next_state;
    calc_pkg::op_t op_q;

    logic [calc_pkg::data_width-1:0]  operand1, operand2;
    logic [calc_pkg::data_width-1:0]  scaled_sum;
    logic [calc_pkg::digit_width-1:0] digit_q;
    logic accept;
    logic unit_done;
    logic any_done;
    logic in_flight;
    logic flush, flush_next;

    assign accept = key_ready && enable;
    assign unit_done = (op_q == calc_pkg::op_mul) ? mul_bus.done : add_bus.done;
    assign any_done = add_bus.done || mul_bus.done;
    assign scaled_sum = mul_bus.result
        + {{(calc_pkg::data_width - calc_pkg::digit_width){1'b0}}, digit_q};

    assign in_flight = (state == calc_pkg::scale1) || (state == calc_pkg::scale2)
        || (state == calc_pkg::wait_result);
    assign busy = !((state == calc_pkg::wait_key1) || (state == calc_pkg::wait_op)
        || (state == calc_pkg::wait_key2));
    assign complete = (state == calc_pkg::show);

    always_comb begin
        next_state = state;
        case (state)
            calc_pkg::wait_key1: begin
                if (accept && key_valid) next_state = calc_pkg::scale1;
            end
            calc_pkg::scale1: begin
                if (mul_bus.done) next_state = calc_pkg::wait_op;
            end
            calc_pkg::wait_op: begin
                if (accept && key_valid) begin
                    next_state = calc_pkg::scale1;
                end else if (accept && op_in != calc_pkg::op_none) begin
                    next_state = calc_pkg::wait_key2;
                end
            end
            calc_pkg::wait_key2: begin
                if (accept && key_valid) begin
                    next_state = calc_pkg::scale2;
                end else if (accept && equal_in) begin
                    next_state = calc_pkg::execute;
                end
            end
            calc_pkg::scale2: begin
                if (mul_bus.done) next_state = calc_pkg::wait_key2;
            end
            calc_pkg::execute:     next_state = calc_pkg::wait_result;
            calc_pkg::wait_result: begin
                if (unit_done) next_state = calc_pkg::show;
            end
            default:               next_state = calc_pkg::wait_key1;
        endcase
        if (clear) next_state = calc_pkg::wait_key1;
    end

    // A unit still running at clear has its done swallowed
    always_comb begin
        flush_next = flush && !any_done;
        if (clear && in_flight && !any_done) flush_next = 1'b1;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= calc_pkg::wait_key1;
            flush <= 1'b0;
            key_ready <= 1'b0;
            add_bus.start <= 1'b0;
            mul_bus.start <= 1'b0;
            operand1 <= '0;
            operand2 <= '0;
            op_q <= calc_pkg::op_none;
            display_out <= '0;
            overflow <= 1'b0;
        end else begin
            state <= next_state;
            flush <= flush_next;
            key_ready <= !flush_next && ((next_state == calc_pkg::wait_key1)
                || (next_state == calc_pkg::wait_op) || (next_state == calc_pkg::wait_key2));
            add_bus.start <= 1'b0;
            mul_bus.start <= 1'b0;
            if (clear) begin
                operand1 <= '0;
                operand2 <= '0;
                op_q <= calc_pkg::op_none;
            end else begin
                case (state)
                    calc_pkg::wait_key1, calc_pkg::wait_op: begin
                        if (next_state == calc_pkg::scale1) mul_bus.start <= 1'b1;
                        if (next_state == calc_pkg::wait_key2) op_q <= op_in;
                    end
                    calc_pkg::wait_key2: begin
                        if (next_state == calc_pkg::scale2) mul_bus.start <= 1'b1;
                    end
                    // entry overflow is ignored, the operand wraps
                    calc_pkg::scale1: begin
                        if (mul_bus.done) operand1 <= scaled_sum;
                    end
                    calc_pkg::scale2: begin
                        if (mul_bus.done) operand2 <= scaled_sum;
                    end
                    calc_pkg::execute: begin
                        if (op_q == calc_pkg::op_mul) begin
                            mul_bus.start <= 1'b1;
                        end else begin
                            add_bus.start <= 1'b1;
                        end
                    end
                    calc_pkg::wait_result: begin
                        if (unit_done) begin
                            display_out <= (op_q == calc_pkg::op_mul) ? mul_bus.result
                                                                      : add_bus.result;
                            overflow <= (op_q == calc_pkg::op_mul) ? mul_bus.overflow
                                                                   : add_bus.overflow;
                        end
                    end
                    calc_pkg::show: begin
                        operand1 <= '0;
                        operand2 <= '0;
                        op_q <= calc_pkg::op_none;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Unit operands and the pending digit
    always_ff @(posedge clk) begin
        case (state)
            calc_pkg::wait_key1, calc_pkg::wait_op: begin
                digit_q <= digit;
                mul_bus.a <= operand1;
                mul_bus.b <= calc_pkg::radix;
            end
            calc_pkg::wait_key2: begin
                digit_q <= digit;
                mul_bus.a <= operand2;
                mul_bus.b <= calc_pkg::radix;
            end
            calc_pkg::execute: begin
                add_bus.a <= operand1;
                add_bus.b <= operand2;
                mul_bus.a <= operand1;
                mul_bus.b <= operand2;
                sub <= (op_q == calc_pkg::op_sub);
            end
            default: ;
        endcase
    end

endmodule

// ==== keypad_calc_top.sv ====
// Keypad calculator top level
module keypad_calc_top (
    input  logic                                   clk,
    input  logic                                   nRST,
    input  logic [calc_pkg::digit_width-1:0]       digit,
    input  logic                                   key_valid,
    input  calc_pkg::op_t                          op_in,
    input  logic                                   equal_in,
    output logic                                   key_ready,
    output logic                                   complete,
    output logic [calc_pkg::data_width-1:0]        display_out,
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  logic [calc_regs_pkg::wb_adr_width-1:0] wb_adr,
    input  logic [calc_pkg::data_width-1:0]        wb_dat_w,
    output logic [calc_pkg::data_width-1:0]        wb_dat_r,
    output logic                                   wb_ack
);

    logic enable;
    logic clear;
    logic busy;
    logic overflow;
    logic sub;

    arith_if add_bus ();
    arith_if mul_bus ();

    entry_controller u_ctrl (
        .clk         (clk),
        .nRST        (nRST),
        .digit       (digit),
        .key_valid   (key_valid),
        .op_in       (op_in),
        .equal_in    (equal_in),
        .enable      (enable),
        .clear       (clear),
        .key_ready   (key_ready),
        .busy        (busy),
        .complete    (complete),
        .display_out (display_out),
        .overflow    (overflow),
        .sub         (sub),
        .add_bus     (add_bus.master),
        .mul_bus     (mul_bus.master)
    );

    add_sub_unit u_add (
        .clk  (clk),
        .nRST (nRST),
        .bus  (add_bus.unit),
        .sub  (sub)
    );

    shift_add_multiplier u_mul (
        .clk  (clk),
        .nRST (nRST),
        .bus  (mul_bus.unit)
    );

    // Result register follows the complete pulse
    calc_regs u_regs (
        .clk          (clk),
        .nRST         (nRST),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .enable       (enable),
        .clear        (clear),
        .busy         (busy),
        .result_valid (complete),
        .result       (display_out),
        .overflow     (overflow)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the keypad calculator simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_keypad_calc \
    --Mdir obj_dir -f verilog.f > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_keypad_calc > sim.log 2>&1

grep -qx "TEST PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== shift_add_multiplier.sv ====
// Sequential shift and add multiplier
module shift_add_multiplier (
    input  logic   clk,
    input  logic   nRST,
    arith_if.unit  bus
);

    logic [2*calc_pkg::data_width-1:0] acc;
    logic [2*calc_pkg::data_width-1:0] acc_next;
    logic [2*calc_pkg::data_width-1:0] mcand;
    logic [calc_pkg::data_width-1:0]   mplier;
    calc_pkg::mult_count_t             count;
    logic                              running;
    logic                              last;

    // Add the shifted multiplicand when the current multiplier bit is set
    assign acc_next = mplier[0] ? acc + mcand : acc;
    assign last = running && (count == calc_pkg::mult_last);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            count <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (bus.start) begin
                running <= 1'b1;
                count <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                if (last) begin
                    running <= 1'b0;
                    bus.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            acc <= '0;
            mcand <= {{calc_pkg::data_width{1'b0}}, bus.a};
            mplier <= bus.b;
        end else if (running) begin
            acc <= acc_next;
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
            // Low half is the result, anything above it overflowed
            if (last) begin
                bus.result <= acc_next[calc_pkg::data_width-1:0];
                bus.overflow <= |acc_next[2*calc_pkg::data_width-1:calc_pkg::data_width];
            end
        end
    end

endmodule

// ==== tb_keypad_calc.sv ====
// Keypad calculator testbench
module tb_keypad_calc;

    typedef logic [calc_pkg::data_width-1:0] word_t;
    typedef logic [calc_regs_pkg::wb_adr_width-1:0] addr_t;

    // Worst case per expression is eight digits plus operator, equal and result
    localparam int num_expr = 28;
    localparam int cycles_per_expr = 4 * 2 * (calc_pkg::mult_cycles + 9) + 40;
    localparam int watchdog_cycles = num_expr * cycles_per_expr + 200;

    logic clk;
    logic nRST;
    logic [calc_pkg::digit_width-1:0] digit;
    logic key_valid;
    calc_pkg::op_t op_in;
    logic equal_in;
    logic key_ready;
    logic complete;
    word_t display_out;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    addr_t wb_adr;
    word_t wb_dat_w;
    word_t wb_dat_r;
    logic wb_ack;

    int seed;
    int errors;
    int checks;
    int completes;
    int expr_total;
    int completes_before;
    string test_name;
    word_t exp_q[$];
    word_t last_result;
    word_t rd;

    keypad_calc_top dut_i (
        .clk         (clk),
        .nRST        (nRST),
        .digit       (digit),
        .key_valid   (key_valid),
        .op_in       (op_in),
        .equal_in    (equal_in),
        .key_ready   (key_ready),
        .complete    (complete),
        .display_out (display_out),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack)
    );

    always #5 clk = ~clk;

    function automatic word_t calc_ref(input int a, input int b,
                                       input calc_pkg::op_t op, output logic ovf);
        int full;
        case (op)
            calc_pkg::op_add: full = a + b;
            calc_pkg::op_sub: full = a - b;
            calc_pkg::op_mul: full = a * b;
            default:          full = 0;
        endcase
        // Overflow is the borrow for subtraction and any bit past 16 otherwise
        if (op == calc_pkg::op_sub) begin
            ovf = (a < b);
        end else begin
            ovf = (full > 65535);
        end
        return full[calc_pkg::data_width-1:0];
    endfunction

    function automatic int random_operand();
        int ndig;
        int v;
        int i;
        ndig = 1 + int'($unsigned($random(seed)) % 4);
        v = 0;
        for (i = 0; i < ndig; i++) begin
            v = v * 10 + int'($unsigned($random(seed)) % 10);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("Mismatch %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic wait_key_ready;
        @(negedge clk);
        while (!key_ready) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic press_key(input int d);
        wait_key_ready();
        digit <= 4'(d);
        key_valid <= 1'b1;
        @(posedge clk);
        key_valid <= 1'b0;
    endtask

    task automatic press_op(input calc_pkg::op_t op);
        wait_key_ready();
        op_in <= op;
        @(posedge clk);
        op_in <= calc_pkg::op_none;
    endtask

    task automatic press_equal;
        wait_key_ready();
        equal_in <= 1'b1;
        @(posedge clk);
        equal_in <= 1'b0;
    endtask

    // Most significant digit first
    task automatic enter_operand(input int value);
        int digits[5];
        int n;
        int v;
        int i;
        n = 0;
        v = value;
        do begin
            digits[n] = v % 10;
            v = v / 10;
            n++;
        end while (v != 0);
        for (i = n - 1; i >= 0; i--) begin
            press_key(digits[i]);
        end
    endtask

    task automatic wb_write(input addr_t addr, input word_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= addr;
        wb_dat_w <= data;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wb_read(input addr_t addr, output word_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= addr;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic wait_complete;
        @(negedge clk);
        while (!complete) @(negedge clk);
    endtask

    task automatic run_expr(input string name, input int a, input int b,
                            input calc_pkg::op_t op);
        word_t expected;
        logic exp_ovf;
        word_t status;
        expected = calc_ref(a, b, op, exp_ovf);
        test_name = name;
        enter_operand(a);
        press_op(op);
        enter_operand(b);
        exp_q.push_back(expected);
        press_equal();
        wait_complete();
        last_result = expected;
        expr_total++;
        wb_read(calc_regs_pkg::reg_status, status);
        check_value({name, " overflow"}, word_t'(exp_ovf),
                    word_t'(status[calc_regs_pkg::status_overflow]));
        check_value({name, " busy"}, 16'h0000,
                    word_t'(status[calc_regs_pkg::status_busy]));
    endtask

    // Every complete pulse must match the oldest pending expression
    always @(negedge clk) begin
        if (complete) begin
            completes++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Complete pulsed during %s with no expression pending", test_name);
            end
            if (exp_q.size() != 0) begin
                check_value(test_name, exp_q.pop_front(), display_out);
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the calculator stopped responding", watchdog_cycles);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk = 1'b0;
        nRST = 1'b0;
        digit = '0;
        key_valid = 1'b0;
        op_in = calc_pkg::op_none;
        equal_in = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        seed = 88383;
        errors = 0;
        checks = 0;
        completes = 0;
        expr_total = 0;
        last_result = '0;
        test_name = "reset";
        repeat (3) @(posedge clk);
        nRST <= 1'b1;

        for (int n = 0; n < 20; n++) begin
            run_expr($sformatf("add_%0d", n), random_operand(), random_operand(),
                     calc_pkg::op_add);
        end
        wb_read(calc_regs_pkg::reg_result, rd);
        check_value("add_last_result", last_result, rd);
        wb_read(calc_regs_pkg::reg_op_count, rd);
        check_value("add_op_count", word_t'(expr_total), rd);

        run_expr("sub_basic", 4821, 1375, calc_pkg::op_sub);
        run_expr("sub_wrap", 25, 300, calc_pkg::op_sub);
        run_expr("mul_small", 123, 45, calc_pkg::op_mul);
        run_expr("mul_wrap", 999, 999, calc_pkg::op_mul);

        // Presses with entry disabled must leave the controller idle
        test_name = "disabled_entry";
        wb_write(calc_regs_pkg::reg_control, 16'h0000);
        completes_before = completes;
        press_key(7);
        press_op(calc_pkg::op_add);
        press_key(8);
        press_equal();
        repeat (2 * (calc_pkg::mult_cycles + 9)) @(posedge clk);
        checks++;
        assert (completes == completes_before) else begin
            errors++;
            $display("Complete pulsed while key entry was disabled");
        end
        wb_write(calc_regs_pkg::reg_control, 16'h0001);
        run_expr("enabled_again", 58, 7, calc_pkg::op_mul);

        // Clear lands while the second operand is still being scaled
        test_name = "clear_mid_entry";
        enter_operand(612);
        press_op(calc_pkg::op_sub);
        press_key(4);
        press_key(9);
        wb_read(calc_regs_pkg::reg_status, rd);
        check_value("busy_mid_entry", 16'h0001, word_t'(rd[calc_regs_pkg::status_busy]));
        wb_write(calc_regs_pkg::reg_control, 16'h0003);
        run_expr("after_clear", 37, 829, calc_pkg::op_add);
        wb_read(calc_regs_pkg::reg_control, rd);
        check_value("control_after_clear", 16'h0001, rd);

        wb_read(calc_regs_pkg::reg_result, rd);
        check_value("final_result", last_result, rd);
        wb_read(calc_regs_pkg::reg_op_count, rd);
        check_value("final_op_count", word_t'(expr_total), rd);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
calc_pkg.sv
calc_regs_pkg.sv
arith_if.sv
add_sub_unit.sv
shift_add_multiplier.sv
entry_controller.sv
calc_regs.sv
keypad_calc_top.sv
tb_keypad_calc.sv
